//--- clct_finder.f
src/clct_pkg.sv
src/pattern_unit.sv
src/best_1of32.sv
src/key_blanking.sv
src/clct_finder.sv
testbench/clct_finder_props.sv
testbench/clct_finder_tb.sv

//--- Bender.yml
package:
  name: clct_finder

sources:
  - src/clct_pkg.sv
  - src/pattern_unit.sv
  - src/best_1of32.sv
  - src/key_blanking.sv
  - src/clct_finder.sv
  - target: test
    files:
      - testbench/clct_finder_props.sv
      - testbench/clct_finder_tb.sv

//--- testbench/clct_finder_tb.sv
`timescale 1ns/1ps

module clct_finder_tb;
  import clct_pkg::*;

  localparam int clock_period = 40;
  localparam int reset_cycles = 16;
  localparam int hit_thresh   = 3;
  localparam int blank_width  = 2;
  localparam int n_random     = 400;
  localparam int drain        = 4;
  // Vectors of each test plus the idle cycles that flush it
  localparam int stim_cycles  = reset_cycles + (4 + drain) + (1 + drain) + (3 + drain)
                                + (2 + drain) + (5 + drain) + (n_random + drain);

  typedef struct packed {
    logic                   v0;
    logic [key_width-1:0]   k0;
    logic [pat_width-1:0]   p0;
    logic [carry_width-1:0] c0;
    logic                   v1;
    logic [key_width-1:0]   k1;
    logic [pat_width-1:0]   p1;
    logic [carry_width-1:0] c1;
  } result_t;

  logic                   clock;
  logic                   reset;
  logic [n_keys-1:0]      ly0_hits;
  logic [n_keys-1:0]      ly1_hits;
  logic [n_keys-1:0]      ly2_hits;
  logic [n_keys-1:0]      ly3_hits;
  logic [n_keys-1:0]      ly4_hits;
  logic [n_keys-1:0]      ly5_hits;
  logic [n_keys-1:0]      dead_keys;
  logic                   clct0_valid;
  logic [key_width-1:0]   clct0_key;
  logic [pat_width-1:0]   clct0_pat;
  logic [carry_width-1:0] clct0_carry;
  logic                   clct1_valid;
  logic [key_width-1:0]   clct1_key;
  logic [pat_width-1:0]   clct1_pat;
  logic [carry_width-1:0] clct1_carry;

  result_t           exp_q [$];
  logic [n_keys-1:0] hv [n_layers];
  logic [n_keys-1:0] dead_mask;
  integer            seed = 92;
  int                test_checks;
  int                test_errors;
  int                total_checks;
  int                total_errors;

  clct_finder #(
    .hit_thresh (hit_thresh),
    .blank_width(blank_width)
  ) u_dut (
    .clock      (clock),
    .reset      (reset),
    .ly0_hits   (ly0_hits),
    .ly1_hits   (ly1_hits),
    .ly2_hits   (ly2_hits),
    .ly3_hits   (ly3_hits),
    .ly4_hits   (ly4_hits),
    .ly5_hits   (ly5_hits),
    .dead_keys  (dead_keys),
    .clct0_valid(clct0_valid),
    .clct0_key  (clct0_key),
    .clct0_pat  (clct0_pat),
    .clct0_carry(clct0_carry),
    .clct1_valid(clct1_valid),
    .clct1_key  (clct1_key),
    .clct1_pat  (clct1_pat),
    .clct1_carry(clct1_carry)
  );

  always #(clock_period / 2) clock = ~clock;

  // ------------------------------
  // Reference model
  // ------------------------------

  // Linear scan where a later key only takes over on a strictly better word
  function automatic int find_best(input logic [pat_width-1:0] pat [n_keys],
                                   input logic [n_keys-1:0]    busy);
    int best;
    best = 0;
    for (int k = 1; k < n_keys; k++) begin
      if (((pat[k][pat_width-1:1] > pat[best][pat_width-1:1]) || busy[best]) && !busy[k]) begin
        best = k;
      end
    end
    return best;
  endfunction

  function automatic result_t predict_results(input logic [n_keys-1:0] hits [n_layers],
                                              input logic [n_keys-1:0] dead);
    logic [pat_width-1:0]   pat [n_keys];
    logic [carry_width-1:0] msk [n_keys];
    logic [carry_width-1:0] m;
    logic [n_keys-1:0]      busy;
    int                     cnt;
    int                     best_cnt;
    int                     best_id;
    int                     hs;
    int                     k0;
    int                     k1;
    result_t                r;
    r = '0;
    for (int k = 0; k < n_keys; k++) begin
      best_cnt = -1;
      best_id  = 0;
      for (int p = 0; p < n_patterns; p++) begin
        cnt = 0;
        for (int ly = 0; ly < n_layers; ly++) begin
          hs    = k + pattern_offset[p][ly];
          m[ly] = (hs >= 0 && hs < n_keys) ? hits[ly][hs] : 1'b0;
          cnt   = cnt + int'(m[ly]);
        end
        // Most hits, then the higher id
        if (cnt > best_cnt || (cnt == best_cnt && int'(pattern_ids[p]) > best_id)) begin
          best_cnt = cnt;
          best_id  = pattern_ids[p];
          msk[k]   = m;
        end
      end
      pat[k] = (best_cnt >= hit_thresh) ? {count_width'(best_cnt), id_width'(best_id)} : '0;
      msk[k] = (best_cnt >= hit_thresh) ? msk[k] : '0;
    end
    k0   = find_best(pat, dead);
    r.v0 = !dead[k0] && (pat[k0][pat_width-1 -: count_width] >= hit_thresh);
    r.k0 = key_width'(k0);
    r.p0 = pat[k0];
    r.c0 = msk[k0];
    busy = dead;
    if (r.v0) begin
      for (int k = k0 - blank_width; k <= k0 + blank_width; k++) begin
        if (k >= 0 && k < n_keys) busy[k] = 1'b1;
      end
    end
    k1   = find_best(pat, busy);
    r.v1 = !busy[k1] && (pat[k1][pat_width-1 -: count_width] >= hit_thresh);
    r.k1 = key_width'(k1);
    r.p1 = pat[k1];
    r.c1 = msk[k1];
    return r;
  endfunction

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  task automatic clear_hits();
    for (int ly = 0; ly < n_layers; ly++) begin
      hv[ly] = '0;
    end
  endtask

  // Track along pattern row p through the first n_ly layers
  task automatic add_track(input int key, input int p, input int n_ly);
    int hs;
    for (int ly = 0; ly < n_ly; ly++) begin
      hs = key + pattern_offset[p][ly];
      if (hs >= 0 && hs < n_keys) hv[ly][hs] = 1'b1;
    end
  endtask

  task automatic drive_cycle();
    @(posedge clock);
    ly0_hits  <= hv[0];
    ly1_hits  <= hv[1];
    ly2_hits  <= hv[2];
    ly3_hits  <= hv[3];
    ly4_hits  <= hv[4];
    ly5_hits  <= hv[5];
    dead_keys <= dead_mask;
    exp_q.push_back(predict_results(hv, dead_mask));
  endtask

  // Flush the pipeline so every vector of the test is checked before the summary
  task automatic end_test(input string name);
    clear_hits();
    repeat (drain) drive_cycle();
    $display("%-16s %0d checks, %0d errors", name, test_checks, test_errors);
    total_checks = total_checks + test_checks;
    total_errors = total_errors + test_errors;
    test_checks  = 0;
    test_errors  = 0;
  endtask

  task automatic compare_value(input string name, input logic [pat_width-1:0] expected,
                               input logic [pat_width-1:0] actual);
    test_checks = test_checks + 1;
    assert (actual === expected) else begin
      $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
      test_errors = test_errors + 1;
    end
  endtask

  // ------------------------------
  // Output comparison
  // ------------------------------

  // Three sets in flight, so the oldest entry matches the outputs after the third edge
  always @(negedge clock) begin
    result_t e;
    if (exp_q.size() > 3) begin
      e = exp_q.pop_front();
      compare_value("clct0_valid", e.v0, clct0_valid);
      if (e.v0) begin
        compare_value("clct0_key", e.k0, clct0_key);
        compare_value("clct0_pat", e.p0, clct0_pat);
        compare_value("clct0_carry", e.c0, clct0_carry);
      end
      compare_value("clct1_valid", e.v1, clct1_valid);
      if (e.v1) begin
        compare_value("clct1_key", e.k1, clct1_key);
        compare_value("clct1_pat", e.p1, clct1_pat);
        compare_value("clct1_carry", e.c1, clct1_carry);
      end
    end
  end

  initial begin
    #((stim_cycles + 50) * clock_period);
    $display("Timeout: run did not finish within %0d cycles", stim_cycles + 50);
    $display("Simulation failed");
    $finish;
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    ly0_hits     = '0;
    ly1_hits     = '0;
    ly2_hits     = '0;
    ly3_hits     = '0;
    ly4_hits     = '0;
    ly5_hits     = '0;
    dead_keys    = '0;
    dead_mask    = '0;
    test_checks  = 0;
    test_errors  = 0;
    total_checks = 0;
    total_errors = 0;
    clear_hits();
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;

    repeat (4) drive_cycle();
    end_test("idle");

    add_track(13, 0, 6);
    drive_cycle();
    end_test("straight_track");

    // Quality order both ways, then a tie
    add_track(5, 0, 6);
    add_track(20, 0, 4);
    drive_cycle();
    clear_hits();
    add_track(5, 0, 4);
    add_track(20, 0, 6);
    drive_cycle();
    clear_hits();
    add_track(8, 0, 6);
    add_track(24, 0, 6);
    drive_cycle();
    end_test("two_tracks");

    dead_mask = n_keys'(1) << 10;
    add_track(10, 0, 6);
    add_track(25, 0, 5);
    add_track(3, 0, 4);
    drive_cycle();
    clear_hits();
    add_track(10, 0, 6);
    drive_cycle();
    end_test("dead_keys");
    dead_mask = '0;

    // Every bent row, then a track below threshold
    for (int p = 1; p < n_patterns; p++) begin
      clear_hits();
      add_track(16, p, 6);
      drive_cycle();
    end
    clear_hits();
    add_track(16, 0, 2);
    drive_cycle();
    end_test("bend_patterns");

    // Sparse hits of about one in four half-strips per layer
    dead_mask = $random(seed) & $random(seed) & $random(seed);
    repeat (n_random) begin
      for (int ly = 0; ly < n_layers; ly++) begin
        hv[ly] = $random(seed) & $random(seed);
      end
      drive_cycle();
    end
    end_test("random_stream");

    // Failed concurrent assertions count as errors too
    total_errors = total_errors + u_dut.u_props.fail_count;
    $display("Total: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- testbench/clct_finder_props.sv
`timescale 1ns/1ps

module clct_finder_props #(
  parameter int blank_width = 2
) (
  input logic                           clock,
  input logic                           reset,
  input logic                           clct0_valid,
  input logic [clct_pkg::key_width-1:0] clct0_key,
  input logic [clct_pkg::pat_width-1:0] clct0_pat,
  input logic                           clct1_valid,
  input logic [clct_pkg::key_width-1:0] clct1_key,
  input logic [clct_pkg::pat_width-1:0] clct1_pat
);
  import clct_pkg::*;

  // Pipeline flags are unknown before the first reset edge
  logic       armed = 1'b0;
  // Cycles left in the quiet window after reset
  logic [1:0] quiet;
  // Number of failed assertions
  int         fail_count = 0;

  always_ff @(posedge clock) begin
    armed <= 1'b1;
    if (reset) begin
      quiet <= 2'd3;
    end else if (quiet != 2'd0) begin
      quiet <= quiet - 2'd1;
    end
  end

  no_valid_in_reset: assert property (@(posedge clock)
    armed && (reset || quiet != 2'd0) |-> !clct0_valid && !clct1_valid)
    else begin
      $error("Valid output high during reset or the three cycles after it");
      fail_count++;
    end

  // Second result lies outside the blanked neighbourhood of the first
  keys_apart: assert property (@(posedge clock) disable iff (reset)
    clct0_valid && clct1_valid |->
      (int'(clct1_key) > int'(clct0_key) + blank_width) ||
      (int'(clct1_key) < int'(clct0_key) - blank_width))
    else begin
      $error("Second key %0d inside blanked range of first key %0d", clct1_key, clct0_key);
      fail_count++;
    end

  quality_order: assert property (@(posedge clock) disable iff (reset)
    clct0_valid && clct1_valid |-> clct0_pat[pat_width-1:1] >= clct1_pat[pat_width-1:1])
    else begin
      $error("Second pattern word ranks above the first");
      fail_count++;
    end

endmodule

bind clct_finder clct_finder_props #(
  .blank_width(blank_width)
) u_props (
  .clock      (clock),
  .reset      (reset),
  .clct0_valid(clct0_valid),
  .clct0_key  (clct0_key),
  .clct0_pat  (clct0_pat),
  .clct1_valid(clct1_valid),
  .clct1_key  (clct1_key),
  .clct1_pat  (clct1_pat)
);

//--- src/clct_finder.sv
`timescale 1ns/1ps

module clct_finder #(
  parameter int hit_thresh  = 3,
  parameter int blank_width = 2
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [clct_pkg::n_keys-1:0]      ly0_hits,
  input  logic [clct_pkg::n_keys-1:0]      ly1_hits,
  input  logic [clct_pkg::n_keys-1:0]      ly2_hits,
  input  logic [clct_pkg::n_keys-1:0]      ly3_hits,
  input  logic [clct_pkg::n_keys-1:0]      ly4_hits,
  input  logic [clct_pkg::n_keys-1:0]      ly5_hits,
  input  logic [clct_pkg::n_keys-1:0]      dead_keys,
  output logic                             clct0_valid,
  output logic [clct_pkg::key_width-1:0]   clct0_key,
  output logic [clct_pkg::pat_width-1:0]   clct0_pat,
  output logic [clct_pkg::carry_width-1:0] clct0_carry,
  output logic                             clct1_valid,
  output logic [clct_pkg::key_width-1:0]   clct1_key,
  output logic [clct_pkg::pat_width-1:0]   clct1_pat,
  output logic [clct_pkg::carry_width-1:0] clct1_carry
);
  import clct_pkg::*;

  // Zero half-strips added on each side of a layer
  localparam int pad = (window_width - 1) / 2;

  logic [n_keys+2*pad-1:0] ly_pad    [n_layers];
  logic [pat_width-1:0]    key_pat   [n_keys];
  logic [carry_width-1:0]  key_carry [n_keys];
  logic [pat_width-1:0]    dly_pat   [n_keys];
  logic [carry_width-1:0]  dly_carry [n_keys];
  logic [n_keys-1:0]       second_busy;
  logic [pat_width-1:0]    first_pat;
  logic [key_width-1:0]    first_key;
  logic [carry_width-1:0]  first_carry;
  logic                    first_bsy;
  logic [pat_width-1:0]    second_pat;
  logic [key_width-1:0]    second_key;
  logic [carry_width-1:0]  second_carry;
  logic                    second_bsy;

  assign ly_pad[0] = {{pad{1'b0}}, ly0_hits, {pad{1'b0}}};
  assign ly_pad[1] = {{pad{1'b0}}, ly1_hits, {pad{1'b0}}};
  assign ly_pad[2] = {{pad{1'b0}}, ly2_hits, {pad{1'b0}}};
  assign ly_pad[3] = {{pad{1'b0}}, ly3_hits, {pad{1'b0}}};
  assign ly_pad[4] = {{pad{1'b0}}, ly4_hits, {pad{1'b0}}};
  assign ly_pad[5] = {{pad{1'b0}}, ly5_hits, {pad{1'b0}}};

  // ----------------------------
  // Pattern units
  // ----------------------------

  // Padded bit k+i is half-strip k-2+i, so each slice is centred on key k
  for (genvar k = 0; k < n_keys; k++) begin : g_key
    pattern_unit #(
      .hit_thresh(hit_thresh)
    ) u_pattern (
      .clock(clock),
      .reset(reset),
      .win0 (ly_pad[0][k +: window_width]),
      .win1 (ly_pad[1][k +: window_width]),
      .win2 (ly_pad[2][k +: window_width]),
      .win3 (ly_pad[3][k +: window_width]),
      .win4 (ly_pad[4][k +: window_width]),
      .win5 (ly_pad[5][k +: window_width]),
      .pat  (key_pat[k]),
      .carry(key_carry[k])
    );
  end

  // ----------------------------
  // First and second best
  // ----------------------------
  best_1of32 u_sort_first (
    .clock(clock),
    .bsy  (dead_keys),
    .pat00(key_pat[0]),  .pat01(key_pat[1]),  .pat02(key_pat[2]),  .pat03(key_pat[3]),
    .pat04(key_pat[4]),  .pat05(key_pat[5]),  .pat06(key_pat[6]),  .pat07(key_pat[7]),
    .pat08(key_pat[8]),  .pat09(key_pat[9]),  .pat10(key_pat[10]), .pat11(key_pat[11]),
    .pat12(key_pat[12]), .pat13(key_pat[13]), .pat14(key_pat[14]), .pat15(key_pat[15]),
    .pat16(key_pat[16]), .pat17(key_pat[17]), .pat18(key_pat[18]), .pat19(key_pat[19]),
    .pat20(key_pat[20]), .pat21(key_pat[21]), .pat22(key_pat[22]), .pat23(key_pat[23]),
    .pat24(key_pat[24]), .pat25(key_pat[25]), .pat26(key_pat[26]), .pat27(key_pat[27]),
    .pat28(key_pat[28]), .pat29(key_pat[29]), .pat30(key_pat[30]), .pat31(key_pat[31]),
    .carry00(key_carry[0]),  .carry01(key_carry[1]),  .carry02(key_carry[2]),
    .carry03(key_carry[3]),  .carry04(key_carry[4]),  .carry05(key_carry[5]),
    .carry06(key_carry[6]),  .carry07(key_carry[7]),  .carry08(key_carry[8]),
    .carry09(key_carry[9]),  .carry10(key_carry[10]), .carry11(key_carry[11]),
    .carry12(key_carry[12]), .carry13(key_carry[13]), .carry14(key_carry[14]),
    .carry15(key_carry[15]), .carry16(key_carry[16]), .carry17(key_carry[17]),
    .carry18(key_carry[18]), .carry19(key_carry[19]), .carry20(key_carry[20]),
    .carry21(key_carry[21]), .carry22(key_carry[22]), .carry23(key_carry[23]),
    .carry24(key_carry[24]), .carry25(key_carry[25]), .carry26(key_carry[26]),
    .carry27(key_carry[27]), .carry28(key_carry[28]), .carry29(key_carry[29]),
    .carry30(key_carry[30]), .carry31(key_carry[31]),
    .best_pat  (first_pat),
    .best_key  (first_key),
    .best_carry(first_carry),
    .best_bsy  (first_bsy)
  );

  key_blanking #(
    .blank_width(blank_width),
    .hit_thresh (hit_thresh)
  ) u_blanking (
    .clock       (clock),
    .reset       (reset),
    .key_pat     (key_pat),
    .key_carry   (key_carry),
    .dead_keys   (dead_keys),
    .first_pat   (first_pat),
    .first_key   (first_key),
    .first_carry (first_carry),
    .first_bsy   (first_bsy),
    .dly_pat     (dly_pat),
    .dly_carry   (dly_carry),
    .second_busy (second_busy),
    .second_pat  (second_pat),
    .second_key  (second_key),
    .second_carry(second_carry),
    .second_bsy  (second_bsy),
    .clct0_valid (clct0_valid),
    .clct0_key   (clct0_key),
    .clct0_pat   (clct0_pat),
    .clct0_carry (clct0_carry),
    .clct1_valid (clct1_valid),
    .clct1_key   (clct1_key),
    .clct1_pat   (clct1_pat),
    .clct1_carry (clct1_carry)
  );

  // Same tree on the delayed words with the winner's neighbourhood busy
  best_1of32 u_sort_second (
    .clock(clock),
    .bsy  (second_busy),
    .pat00(dly_pat[0]),  .pat01(dly_pat[1]),  .pat02(dly_pat[2]),  .pat03(dly_pat[3]),
    .pat04(dly_pat[4]),  .pat05(dly_pat[5]),  .pat06(dly_pat[6]),  .pat07(dly_pat[7]),
    .pat08(dly_pat[8]),  .pat09(dly_pat[9]),  .pat10(dly_pat[10]), .pat11(dly_pat[11]),
    .pat12(dly_pat[12]), .pat13(dly_pat[13]), .pat14(dly_pat[14]), .pat15(dly_pat[15]),
    .pat16(dly_pat[16]), .pat17(dly_pat[17]), .pat18(dly_pat[18]), .pat19(dly_pat[19]),
    .pat20(dly_pat[20]), .pat21(dly_pat[21]), .pat22(dly_pat[22]), .pat23(dly_pat[23]),
    .pat24(dly_pat[24]), .pat25(dly_pat[25]), .pat26(dly_pat[26]), .pat27(dly_pat[27]),
    .pat28(dly_pat[28]), .pat29(dly_pat[29]), .pat30(dly_pat[30]), .pat31(dly_pat[31]),
    .carry00(dly_carry[0]),  .carry01(dly_carry[1]),  .carry02(dly_carry[2]),
    .carry03(dly_carry[3]),  .carry04(dly_carry[4]),  .carry05(dly_carry[5]),
    .carry06(dly_carry[6]),  .carry07(dly_carry[7]),  .carry08(dly_carry[8]),
    .carry09(dly_carry[9]),  .carry10(dly_carry[10]), .carry11(dly_carry[11]),
    .carry12(dly_carry[12]), .carry13(dly_carry[13]), .carry14(dly_carry[14]),
    .carry15(dly_carry[15]), .carry16(dly_carry[16]), .carry17(dly_carry[17]),
    .carry18(dly_carry[18]), .carry19(dly_carry[19]), .carry20(dly_carry[20]),
    .carry21(dly_carry[21]), .carry22(dly_carry[22]), .carry23(dly_carry[23]),
    .carry24(dly_carry[24]), .carry25(dly_carry[25]), .carry26(dly_carry[26]),
    .carry27(dly_carry[27]), .carry28(dly_carry[28]), .carry29(dly_carry[29]),
    .carry30(dly_carry[30]), .carry31(dly_carry[31]),
    .best_pat  (second_pat),
    .best_key  (second_key),
    .best_carry(second_carry),
    .best_bsy  (second_bsy)
  );

endmodule

//--- src/key_blanking.sv
`timescale 1ns/1ps

module key_blanking #(
  parameter int blank_width = 2,
  parameter int hit_thresh  = 3
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic [clct_pkg::pat_width-1:0]   key_pat   [clct_pkg::n_keys],
  input  logic [clct_pkg::carry_width-1:0] key_carry [clct_pkg::n_keys],
  input  logic [clct_pkg::n_keys-1:0]      dead_keys,
  input  logic [clct_pkg::pat_width-1:0]   first_pat,
  input  logic [clct_pkg::key_width-1:0]   first_key,
  input  logic [clct_pkg::carry_width-1:0] first_carry,
  input  logic                             first_bsy,
  output logic [clct_pkg::pat_width-1:0]   dly_pat   [clct_pkg::n_keys],
  output logic [clct_pkg::carry_width-1:0] dly_carry [clct_pkg::n_keys],
  output logic [clct_pkg::n_keys-1:0]      second_busy,
  input  logic [clct_pkg::pat_width-1:0]   second_pat,
  input  logic [clct_pkg::key_width-1:0]   second_key,
  input  logic [clct_pkg::carry_width-1:0] second_carry,
  input  logic                             second_bsy,
  output logic                             clct0_valid,
  output logic [clct_pkg::key_width-1:0]   clct0_key,
  output logic [clct_pkg::pat_width-1:0]   clct0_pat,
  output logic [clct_pkg::carry_width-1:0] clct0_carry,
  output logic                             clct1_valid,
  output logic [clct_pkg::key_width-1:0]   clct1_key,
  output logic [clct_pkg::pat_width-1:0]   clct1_pat,
  output logic [clct_pkg::carry_width-1:0] clct1_carry
);
  import clct_pkg::*;

  logic [n_keys-1:0] dly_dead;
  logic              clct0_bsy;
  logic              first_valid;
  // Pipeline fill after reset with one bit per stage
  logic [2:0]        fill;

  always_ff @(posedge clock) begin
    if (reset) begin
      fill <= '0;
    end else begin
      fill <= {fill[1:0], 1'b1};
    end
  end

  // Line the pattern arrays up with the first result, then hold that result one more cycle
  always_ff @(posedge clock) begin
    dly_pat     <= key_pat;
    dly_carry   <= key_carry;
    dly_dead    <= dead_keys;
    clct0_pat   <= first_pat;
    clct0_key   <= first_key;
    clct0_carry <= first_carry;
    clct0_bsy   <= first_bsy;
  end

  assign first_valid = fill[1] && !first_bsy &&
                       (first_pat[pat_width-1 -: count_width] >= hit_thresh);

  // Winner and neighbours join the dead keys, clipped at the section edges
  always_comb begin
    second_busy = dly_dead;
    for (int k = 0; k < n_keys; k++) begin
      if (first_valid && (k >= int'(first_key) - blank_width) &&
          (k <= int'(first_key) + blank_width)) begin
        second_busy[k] = 1'b1;
      end
    end
  end

  assign clct0_valid = fill[2] && !clct0_bsy &&
                       (clct0_pat[pat_width-1 -: count_width] >= hit_thresh);
  assign clct1_valid = fill[2] && !second_bsy &&
                       (second_pat[pat_width-1 -: count_width] >= hit_thresh);
  assign clct1_key   = second_key;
  assign clct1_pat   = second_pat;
  assign clct1_carry = second_carry;

endmodule

//--- src/best_1of32.sv
`timescale 1ns/1ps

module best_1of32 (
  input  logic                             clock,
  input  logic [clct_pkg::n_keys-1:0]      bsy,
  input  logic [clct_pkg::pat_width-1:0]
    pat00, pat01, pat02, pat03, pat04, pat05, pat06, pat07,
    pat08, pat09, pat10, pat11, pat12, pat13, pat14, pat15,
    pat16, pat17, pat18, pat19, pat20, pat21, pat22, pat23,
    pat24, pat25, pat26, pat27, pat28, pat29, pat30, pat31,
  input  logic [clct_pkg::carry_width-1:0]
    carry00, carry01, carry02, carry03, carry04, carry05, carry06, carry07,
    carry08, carry09, carry10, carry11, carry12, carry13, carry14, carry15,
    carry16, carry17, carry18, carry19, carry20, carry21, carry22, carry23,
    carry24, carry25, carry26, carry27, carry28, carry29, carry30, carry31,
  output logic [clct_pkg::pat_width-1:0]   best_pat,
  output logic [clct_pkg::key_width-1:0]   best_key,
  output logic [clct_pkg::carry_width-1:0] best_carry,
  output logic                             best_bsy
);
  import clct_pkg::*;

  // Upper beats lower on a larger sort field or a busy lower but never when itself busy
  function automatic logic upper_wins(input logic [pat_width-1:0] lo_pat,
                                      input logic [pat_width-1:0] hi_pat,
                                      input logic                 lo_bsy,
                                      input logic                 hi_bsy);
    return ((hi_pat[pat_width-1:1] > lo_pat[pat_width-1:1]) || lo_bsy) && !hi_bsy;
  endfunction

  logic [pat_width-1:0]   pat_in   [n_keys];
  logic [carry_width-1:0] carry_in [n_keys];

  // Tree node n has lower child 2n and upper child 2n+1
  // Leaves sit at n_keys + key
  logic [pat_width-1:0]   pat_t   [2:2*n_keys-1];
  logic [carry_width-1:0] carry_t [2:2*n_keys-1];
  logic [key_width-1:0]   key_t   [2:2*n_keys-1];
  logic                   bsy_t   [2:2*n_keys-1];

  // 2-of-4 pipeline register
  logic [pat_width-1:0]   pat_r   [2];
  logic [carry_width-1:0] carry_r [2];
  logic [key_width-1:0]   key_r   [2];
  logic                   bsy_r   [2];
  logic                   up_final;

  assign pat_in = '{pat00, pat01, pat02, pat03, pat04, pat05, pat06, pat07,
                    pat08, pat09, pat10, pat11, pat12, pat13, pat14, pat15,
                    pat16, pat17, pat18, pat19, pat20, pat21, pat22, pat23,
                    pat24, pat25, pat26, pat27, pat28, pat29, pat30, pat31};

  assign carry_in = '{carry00, carry01, carry02, carry03, carry04, carry05, carry06, carry07,
                      carry08, carry09, carry10, carry11, carry12, carry13, carry14, carry15,
                      carry16, carry17, carry18, carry19, carry20, carry21, carry22, carry23,
                      carry24, carry25, carry26, carry27, carry28, carry29, carry30, carry31};

  // ----------------------------
  // Best 16, 8, 4 and 2 levels
  // ----------------------------
  for (genvar n = 2; n < 2 * n_keys; n++) begin : g_tree
    if (n >= n_keys) begin : g_leaf
      assign pat_t[n]   = pat_in[n-n_keys];
      assign carry_t[n] = carry_in[n-n_keys];
      assign key_t[n]   = '0;
      assign bsy_t[n]   = bsy[n-n_keys];
    end else begin : g_node
      // Key bit this level appends
      localparam int kbit = key_width - $clog2(n + 1);
      logic up;

      assign up         = upper_wins(pat_t[2*n], pat_t[2*n+1], bsy_t[2*n], bsy_t[2*n+1]);
      assign pat_t[n]   = up ? pat_t[2*n+1] : pat_t[2*n];
      assign carry_t[n] = up ? carry_t[2*n+1] : carry_t[2*n];
      assign bsy_t[n]   = up ? bsy_t[2*n+1] : bsy_t[2*n];
      assign key_t[n]   = (up ? key_t[2*n+1] : key_t[2*n]) | (key_width'(up) << kbit);
    end
  end

  always_ff @(posedge clock) begin
    pat_r[0]   <= pat_t[2];
    pat_r[1]   <= pat_t[3];
    carry_r[0] <= carry_t[2];
    carry_r[1] <= carry_t[3];
    key_r[0]   <= key_t[2];
    key_r[1]   <= key_t[3];
    bsy_r[0]   <= bsy_t[2];
    bsy_r[1]   <= bsy_t[3];
  end

  // ----------------------------
  // Best 1 of 2
  // ----------------------------
  assign up_final   = upper_wins(pat_r[0], pat_r[1], bsy_r[0], bsy_r[1]);
  assign best_pat   = up_final ? pat_r[1] : pat_r[0];
  assign best_carry = up_final ? carry_r[1] : carry_r[0];
  assign best_bsy   = up_final ? bsy_r[1] : bsy_r[0];
  assign best_key   = (up_final ? key_r[1] : key_r[0]) | (key_width'(up_final) << (key_width - 1));

endmodule

//--- src/pattern_unit.sv
`timescale 1ns/1ps

module pattern_unit #(
  parameter int hit_thresh = 3
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [clct_pkg::window_width-1:0] win0,
  input  logic [clct_pkg::window_width-1:0] win1,
  input  logic [clct_pkg::window_width-1:0] win2,
  input  logic [clct_pkg::window_width-1:0] win3,
  input  logic [clct_pkg::window_width-1:0] win4,
  input  logic [clct_pkg::window_width-1:0] win5,
  output logic [clct_pkg::pat_width-1:0]    pat,
  output logic [clct_pkg::carry_width-1:0]  carry
);
  import clct_pkg::*;

  // Window bit of the key half-strip itself
  localparam int centre = (window_width - 1) / 2;

  logic [window_width-1:0] win [n_layers];
  logic [carry_width-1:0]  msk [n_patterns];
  logic [count_width-1:0]  cnt [n_patterns];
  logic [count_width-1:0]  best_cnt;
  logic [id_width-1:0]     best_id;
  logic [carry_width-1:0]  best_msk;

  assign win = '{win0, win1, win2, win3, win4, win5};

  // ----------------------------
  // Score every pattern
  // ----------------------------

  // One bit per layer at the pattern's offset, then count them
  always_comb begin
    for (int p = 0; p < n_patterns; p++) begin
      cnt[p] = '0;
      for (int ly = 0; ly < n_layers; ly++) begin
        msk[p][ly] = win[ly][centre + pattern_offset[p][ly]];
        cnt[p]     = cnt[p] + count_width'(msk[p][ly]);
      end
    end
  end

  // Most hits wins
  // Only a strictly larger count replaces the current pick, so ties keep the higher id
  always_comb begin
    best_cnt = cnt[0];
    best_id  = pattern_ids[0];
    best_msk = msk[0];
    for (int p = 1; p < n_patterns; p++) begin
      if (cnt[p] > best_cnt) begin
        best_cnt = cnt[p];
        best_id  = pattern_ids[p];
        best_msk = msk[p];
      end
    end
  end

  // ----------------------------
  // Output register
  // ----------------------------

  // Words below threshold leave as zero
  always_ff @(posedge clock) begin
    if (reset) begin
      pat   <= '0;
      carry <= '0;
    end else if (best_cnt >= hit_thresh) begin
      pat   <= {best_cnt, best_id};
      carry <= best_msk;
    end else begin
      pat   <= '0;
      carry <= '0;
    end
  end

endmodule

//--- src/clct_pkg.sv
package clct_pkg;

  // ----------------------------
  // Chamber section geometry
  // ----------------------------
  localparam int n_keys       = 32;
  localparam int key_width    = 5;
  localparam int n_layers     = 6;
  localparam int window_width = 5;

  // Pattern word is {hit count, pattern id}
  // Id lsb gives the bend direction and is left out of the sort
  localparam int count_width = 3;
  localparam int id_width    = 4;
  localparam int pat_width   = count_width + id_width;

  // Layer-hit mask of the chosen pattern with bit n for layer n
  localparam int carry_width = n_layers;

  // ----------------------------
  // Pattern set
  // ----------------------------
  localparam int n_patterns = 5;

  // Higher ids first so the straighter pattern sits earlier in the table
  localparam logic [id_width-1:0] pattern_ids [n_patterns] = '{4'd8, 4'd7, 4'd6, 4'd5, 4'd4};

  // Half-strip offset from the key per layer in the row order of pattern_ids
  localparam int pattern_offset [n_patterns][n_layers] = '{
    '{ 0,  0,  0,  0,  0,  0},  // straight
    '{ 1,  1,  0,  0, -1, -1},
    '{-1, -1,  0,  0,  1,  1},
    '{ 2,  1,  1, -1, -1, -2},
    '{-2, -1, -1,  1,  1,  2}
  };

endpackage
